/* hw/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Bus widths
`define DC_ADDR_W 64
`define DC_DATA_W 64           // Also the AXI beat width

// Geometry
`define DC_LINE_BEATS 8        // 64-byte line
`define DC_SETS 2
`define DC_WAYS 2

// Address split
`define DC_OFFSET_W 6
`define DC_INDEX_W 1
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

/* hw/dcache_pkg.sv */
`default_nettype none
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_DATA_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [$clog2(`DC_LINE_BEATS)-1:0] beat_t;
    typedef logic [`DC_LINE_BEATS*`DC_DATA_W-1:0] line_t;

    // Core access size codes
    typedef enum logic [2:0] {
        SIZE_B = 3'd1,
        SIZE_H = 3'd2,
        SIZE_W = 3'd4,
        SIZE_D = 3'd7
    } size_e;

    typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, RELEASE} ctrl_state_e;

endpackage

`default_nettype wire

/* hw/dcache_lane_align.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_lane_align import dcache_pkg::*; (
    input  addr_t address,
    input  size_e data_size,
    input  logic load_sign,
    input  word_t data_input,
    input  word_t hit_word,
    output word_t load_word,
    output word_t store_word,
    output logic [`DC_DATA_W/8-1:0] store_mask
);

    localparam int OFF_W = $clog2(`DC_DATA_W / 8);

    logic [OFF_W-1:0] byte_off;
    logic [OFF_W-1:0] align_mask;
    logic [`DC_DATA_W/8-1:0] size_mask;
    word_t shifted;

    assign byte_off = address[OFF_W-1:0];
    assign shifted = hit_word >> {byte_off, 3'b000};    // Requested bytes down to bit 0

    always_comb begin
        case (data_size)
            SIZE_B: begin
                size_mask = 'h01;
                align_mask = 'd0;
                load_word = {{(`DC_DATA_W-8){load_sign && shifted[7]}}, shifted[7:0]};
            end
            SIZE_H: begin
                size_mask = 'h03;
                align_mask = 'd1;
                load_word = {{(`DC_DATA_W-16){load_sign && shifted[15]}}, shifted[15:0]};
            end
            SIZE_W: begin
                size_mask = 'h0f;
                align_mask = 'd3;
                load_word = {{(`DC_DATA_W-32){load_sign && shifted[31]}}, shifted[31:0]};
            end
            default: begin                               // Full doubleword
                size_mask = '1;
                align_mask = '1;
                load_word = shifted;
            end
        endcase
    end

    assign store_word = data_input << {byte_off, 3'b000};
    assign store_mask = size_mask << byte_off;

    // Misaligned requests would split across beats
    always_comb begin
        if (!$isunknown({byte_off, data_size}))
            a_aligned: assert final ((byte_off & align_mask) == '0)
                else $error("misaligned access at %h", address);
    end

endmodule

`default_nettype wire

/* hw/dcache_store.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_store import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  addr_t address,
    input  logic fill,
    input  line_t fill_line,
    input  logic store_write,
    input  word_t store_word,
    input  logic [`DC_DATA_W/8-1:0] store_mask,
    output logic hit,
    output word_t hit_word,
    output logic victim_dirty,
    output tag_t victim_tag,
    output line_t victim_line
);

    localparam int WAY_W = $clog2(`DC_WAYS);

    tag_t tags [`DC_SETS][`DC_WAYS];
    line_t lines [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0] valid [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty [`DC_SETS];
    logic [WAY_W-1:0] rr_way;           // Round-robin victim pointer

    index_t set_idx;
    tag_t tag;
    beat_t beat;
    logic [`DC_WAYS-1:0] hit_vec;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;
    word_t merged_word;

    assign set_idx = address[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag = address[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign beat = address[`DC_OFFSET_W-1 -: $bits(beat_t)];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
            if (hit_vec[w])
                hit_way = WAY_W'(w);
        end
    end

    assign hit = |hit_vec;
    assign hit_word = lines[set_idx][hit_way][beat * `DC_DATA_W +: `DC_DATA_W];

    // An empty way wins over the round-robin pick
    always_comb begin
        victim_way = rr_way;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid[set_idx][w])
                victim_way = WAY_W'(w);
        end
    end

    assign victim_dirty = valid[set_idx][victim_way] && dirty[set_idx][victim_way];
    assign victim_tag = tags[set_idx][victim_way];
    assign victim_line = lines[set_idx][victim_way];

    always_comb begin
        for (int b = 0; b < `DC_DATA_W / 8; b++)
            merged_word[8*b +: 8] = store_mask[b] ? store_word[8*b +: 8] : hit_word[8*b +: 8];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            rr_way <= '0;
        end else if (fill) begin
            valid[set_idx][victim_way] <= 1'b1;
            dirty[set_idx][victim_way] <= 1'b0;   // Fresh line is clean
            rr_way <= rr_way + 1'b1;
        end else if (store_write) begin
            dirty[set_idx][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            tags[set_idx][victim_way] <= tag;
            lines[set_idx][victim_way] <= fill_line;
        end else if (store_write) begin
            lines[set_idx][hit_way][beat * `DC_DATA_W +: `DC_DATA_W] <= merged_word;
        end
    end

    a_single_hit: assert property (@(posedge clock) disable iff (reset) $onehot0(hit_vec))
        else $error("tag matches in more than one way");

endmodule

`default_nettype wire

/* hw/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic read_enable,
    input  logic write_enable,
    input  logic hit,
    input  logic victim_dirty,
    input  word_t load_word,
    input  logic refill_done,
    input  logic wb_done,
    output logic refill_start,
    output logic wb_start,
    output logic fill,
    output logic store_write,
    output word_t data_out,
    output logic send_enable
);

    ctrl_state_e state, next_state;
    logic request;
    logic lookup_hit;
    logic lookup_miss;

    assign request = read_enable || write_enable;
    assign lookup_hit = (state == LOOKUP) && hit;
    assign lookup_miss = (state == LOOKUP) && !hit;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (request)
                    next_state = LOOKUP;
            end
            LOOKUP: begin
                if (hit)
                    next_state = RELEASE;
                else if (victim_dirty)
                    next_state = WRITEBACK;   // Old line goes out first
                else
                    next_state = REFILL;
            end
            WRITEBACK: begin
                if (wb_done)
                    next_state = REFILL;
            end
            REFILL: begin
                if (refill_done)
                    next_state = LOOKUP;      // Retry now hits the new line
            end
            RELEASE: begin
                // Core must drop both enables before the next request
                if (!request)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    assign store_write = lookup_hit && write_enable;
    assign wb_start = lookup_miss && victim_dirty;
    assign refill_start = (lookup_miss && !victim_dirty) || ((state == WRITEBACK) && wb_done);
    assign fill = (state == REFILL) && refill_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            send_enable <= 1'b0;
        end else begin
            state <= next_state;
            send_enable <= lookup_hit;  // One cycle, first cycle of RELEASE
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_hit && read_enable)
            data_out <= load_word;
    end

    a_send_from_lookup: assert property (@(posedge clock) disable iff (reset)
        $rose(send_enable) |-> $past(state) == LOOKUP)
        else $error("send_enable rose outside LOOKUP");

endmodule

`default_nettype wire

/* hw/dcache_axi_master.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_axi_master import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  addr_t address,
    input  tag_t victim_tag,
    input  line_t victim_line,
    input  logic refill_start,
    input  logic wb_start,
    output line_t fill_line,
    output logic refill_done,
    output logic wb_done,
    output logic m_axi_arvalid,
    input  logic m_axi_arready,
    output addr_t m_axi_araddr,
    output logic [7:0] m_axi_arlen,
    output logic [2:0] m_axi_arsize,
    output logic [1:0] m_axi_arburst,
    input  logic m_axi_rvalid,
    output logic m_axi_rready,
    input  logic m_axi_rlast,
    input  word_t m_axi_rdata,
    output logic m_axi_awvalid,
    input  logic m_axi_awready,
    output addr_t m_axi_awaddr,
    output logic [7:0] m_axi_awlen,
    output logic [2:0] m_axi_awsize,
    output logic [1:0] m_axi_awburst,
    output word_t m_axi_wdata,
    output logic [`DC_DATA_W/8-1:0] m_axi_wstrb,
    output logic m_axi_wvalid,
    input  logic m_axi_wready,
    output logic m_axi_wlast,
    input  logic m_axi_bvalid,
    output logic m_axi_bready,
    input  logic [1:0] m_axi_bresp     // Response code is not inspected
);

    beat_t beat_cnt;    // Shared by both bursts, only one runs at a time

    assign m_axi_araddr = {address[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign m_axi_arlen = 8'(`DC_LINE_BEATS - 1);
    assign m_axi_arsize = 3'($clog2(`DC_DATA_W / 8));
    assign m_axi_arburst = 2'b01;                        // INCR
    assign m_axi_awaddr = {victim_tag, address[`DC_OFFSET_W +: `DC_INDEX_W],
                           {`DC_OFFSET_W{1'b0}}};
    assign m_axi_awlen = m_axi_arlen;
    assign m_axi_awsize = m_axi_arsize;
    assign m_axi_awburst = m_axi_arburst;
    assign m_axi_wdata = victim_line[beat_cnt * `DC_DATA_W +: `DC_DATA_W];
    assign m_axi_wstrb = '1;

    always_ff @(posedge clock) begin
        if (reset) begin
            {m_axi_arvalid, m_axi_rready, m_axi_awvalid} <= '0;
            {m_axi_wvalid, m_axi_wlast, m_axi_bready} <= '0;
            {refill_done, wb_done} <= '0;
            beat_cnt <= '0;
        end else begin
            refill_done <= m_axi_rvalid && m_axi_rready && m_axi_rlast;
            wb_done <= m_axi_bvalid && m_axi_bready;
            if (refill_start || wb_start)
                beat_cnt <= '0;
            if (refill_start)
                m_axi_arvalid <= 1'b1;
            if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
                m_axi_rready <= 1'b1;
            end
            if (m_axi_rvalid && m_axi_rready) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (m_axi_rlast)
                    m_axi_rready <= 1'b0;
            end
            if (wb_start)
                m_axi_awvalid <= 1'b1;
            if (m_axi_awvalid && m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
                m_axi_wvalid <= 1'b1;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                beat_cnt <= beat_cnt + 1'b1;
                m_axi_wlast <= (beat_cnt == beat_t'(`DC_LINE_BEATS - 2));
                if (m_axi_wlast) begin
                    m_axi_wvalid <= 1'b0;
                    m_axi_wlast <= 1'b0;
                    m_axi_bready <= 1'b1;
                end
            end
            if (m_axi_bvalid && m_axi_bready)
                m_axi_bready <= 1'b0;
        end
    end

    // Line buffer for the incoming burst
    always_ff @(posedge clock) begin
        if (m_axi_rvalid && m_axi_rready)
            fill_line[beat_cnt * `DC_DATA_W +: `DC_DATA_W] <= m_axi_rdata;
    end

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr));

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr));

    a_aw_aligned: assert property (@(posedge clock) disable iff (reset)
        m_axi_awvalid |-> m_axi_awaddr[`DC_OFFSET_W-1:0] == '0);

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
    input  logic clock,
    input  logic reset,
    // Core request and response
    input  logic read_enable,
    input  logic write_enable,
    input  addr_t address,
    input  size_e data_size,
    input  logic load_sign,
    input  word_t data_input,
    output word_t data_out,
    output logic send_enable,
    // AXI read channels
    output logic m_axi_arvalid,
    input  logic m_axi_arready,
    output addr_t m_axi_araddr,
    output logic [7:0] m_axi_arlen,
    output logic [2:0] m_axi_arsize,
    output logic [1:0] m_axi_arburst,
    input  logic m_axi_rvalid,
    output logic m_axi_rready,
    input  logic m_axi_rlast,
    input  word_t m_axi_rdata,
    // AXI write channels
    output logic m_axi_awvalid,
    input  logic m_axi_awready,
    output addr_t m_axi_awaddr,
    output logic [7:0] m_axi_awlen,
    output logic [2:0] m_axi_awsize,
    output logic [1:0] m_axi_awburst,
    output word_t m_axi_wdata,
    output logic [`DC_DATA_W/8-1:0] m_axi_wstrb,
    output logic m_axi_wvalid,
    input  logic m_axi_wready,
    output logic m_axi_wlast,
    input  logic m_axi_bvalid,
    output logic m_axi_bready,
    input  logic [1:0] m_axi_bresp
);

    logic hit, victim_dirty, fill, store_write;
    logic refill_start, wb_start, refill_done, wb_done;
    word_t hit_word, load_word, store_word;
    logic [`DC_DATA_W/8-1:0] store_mask;
    tag_t victim_tag;
    line_t victim_line, fill_line;

    dcache_ctrl u_ctrl (.*);

    dcache_store u_store (.*);

    dcache_lane_align u_lane_align (.*);

    dcache_axi_master u_axi_master (.*);

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module axi_mem_model import dcache_pkg::*; #(
    parameter int WORDS = 4096,
    parameter int WAIT_LIMIT = 1000
) (
    input  logic clock,
    input  logic arvalid,
    output logic arready,
    input  addr_t araddr,
    output logic rvalid,
    input  logic rready,
    output logic rlast,
    output word_t rdata,
    input  logic awvalid,
    output logic awready,
    input  addr_t awaddr,
    input  word_t wdata,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,
    output logic stalled        // Some DUT handshake never came
);

    localparam int IDX_W = $clog2(WORDS);

    word_t words [WORDS];

    function automatic word_t pattern_word(input addr_t a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], ~a[63:32]};
    endfunction

    initial begin
        stalled = 1'b0;
        bresp = 2'b00;
        for (int i = 0; i < WORDS; i++)
            words[i] = pattern_word(addr_t'(i) << 3);
    end

    // Read side, all signals change on the falling edge
    initial begin : read_side
        int base;
        int n;
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        forever begin
            @(negedge clock);
            if (arvalid) begin
                repeat ($urandom_range(3)) @(negedge clock);
                arready = 1'b1;                      // Taken at the next rising edge
                base = int'(araddr[3 +: IDX_W]);
                @(negedge clock);
                arready = 1'b0;
                for (int b = 0; b < `DC_LINE_BEATS; b++) begin
                    repeat ($urandom_range(3)) @(negedge clock);
                    rvalid = 1'b1;
                    rdata = words[base + b];
                    rlast = (b == `DC_LINE_BEATS - 1);
                    n = 0;
                    while (!rready && n < WAIT_LIMIT) begin
                        @(negedge clock);
                        n++;
                    end
                    if (!rready)
                        stalled = 1'b1;
                    @(negedge clock);
                    rvalid = 1'b0;
                    rlast = 1'b0;
                end
            end
        end
    end

    initial begin : write_side
        int base;
        int n;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        forever begin
            @(negedge clock);
            if (awvalid) begin
                repeat ($urandom_range(3)) @(negedge clock);
                awready = 1'b1;
                base = int'(awaddr[3 +: IDX_W]);
                @(negedge clock);
                awready = 1'b0;
                for (int b = 0; b < `DC_LINE_BEATS; b++) begin
                    repeat ($urandom_range(3)) @(negedge clock);
                    wready = 1'b1;
                    n = 0;
                    while (!wvalid && n < WAIT_LIMIT) begin
                        @(negedge clock);
                        n++;
                    end
                    if (!wvalid)
                        stalled = 1'b1;
                    words[base + b] = wdata;         // Beat accepted at the next rising edge
                    @(negedge clock);
                    wready = 1'b0;
                end
                bvalid = 1'b1;
                n = 0;
                while (!bready && n < WAIT_LIMIT) begin
                    @(negedge clock);
                    n++;
                end
                if (!bready)
                    stalled = 1'b1;
                @(negedge clock);
                bvalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int SEED = 32'h677d;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_OPS = 300;
    localparam int MEM_BYTES = 32768;

    logic clock, reset;
    logic read_enable, write_enable, load_sign, send_enable;
    addr_t address;
    size_e data_size;
    word_t data_input, data_out;
    logic m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
    logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_wlast;
    logic m_axi_bvalid, m_axi_bready, mem_stalled;
    addr_t m_axi_araddr, m_axi_awaddr;
    word_t m_axi_rdata, m_axi_wdata;
    logic [7:0] m_axi_arlen, m_axi_awlen, m_axi_wstrb;
    logic [2:0] m_axi_arsize, m_axi_awsize;
    logic [1:0] m_axi_arburst, m_axi_awburst, m_axi_bresp;

    logic [7:0] shadow [MEM_BYTES];     // Byte image of what memory should hold
    word_t expected_data;
    logic load_active;
    int mismatches;
    int timeouts;
    int w_beats;                        // W beats taken in the current burst
    logic read_open;                    // AR accepted, last R beat not yet taken
    logic resp_open;                    // Last W beat taken, B not yet taken

    dcache_top UUT (.*);

    axi_mem_model #(.WORDS(MEM_BYTES / 8)) mem (
        .clock(clock),
        .arvalid(m_axi_arvalid),
        .arready(m_axi_arready),
        .araddr(m_axi_araddr),
        .rvalid(m_axi_rvalid),
        .rready(m_axi_rready),
        .rlast(m_axi_rlast),
        .rdata(m_axi_rdata),
        .awvalid(m_axi_awvalid),
        .awready(m_axi_awready),
        .awaddr(m_axi_awaddr),
        .wdata(m_axi_wdata),
        .wvalid(m_axi_wvalid),
        .wready(m_axi_wready),
        .bvalid(m_axi_bvalid),
        .bready(m_axi_bready),
        .bresp(m_axi_bresp),
        .stalled(mem_stalled)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Same address pattern the memory model starts with
    function automatic word_t memory_word(input addr_t a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], ~a[63:32]};
    endfunction

    function automatic int size_bytes(input size_e size);
        case (size)
            SIZE_B: return 1;
            SIZE_H: return 2;
            SIZE_W: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic size_e size_code(input int nbytes);
        case (nbytes)
            1: return SIZE_B;
            2: return SIZE_H;
            4: return SIZE_W;
            default: return SIZE_D;
        endcase
    endfunction

    function automatic word_t shadow_word(input addr_t addr);
        word_t w;
        int base;
        base = int'(addr % MEM_BYTES) & ~7;
        for (int i = 0; i < 8; i++)
            w[8*i +: 8] = shadow[base + i];
        return w;
    endfunction

    // Picks the addressed bytes out of the word, then extends
    function automatic word_t expected_load(input word_t word, input int offset,
                                            input size_e size, input logic sign);
        int nbytes;
        word_t value;
        nbytes = size_bytes(size);
        value = '0;
        for (int i = 0; i < nbytes; i++)
            value[8*i +: 8] = word[8*(offset + i) +: 8];
        if (sign && value[8*nbytes - 1]) begin
            for (int i = nbytes; i < 8; i++)
                value[8*i +: 8] = 8'hff;
        end
        return value;
    endfunction

    function automatic logic line_in_memory(input addr_t line);
        logic same;
        same = 1'b1;
        for (int b = 0; b < `DC_LINE_BEATS; b++) begin
            if (mem.words[int'((line % MEM_BYTES) >> 3) + b] !== shadow_word(line + 8 * b))
                same = 1'b0;
        end
        return same;
    endfunction

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // One core request, held until send_enable
    task automatic access(input logic is_store, input addr_t addr, input size_e size,
                          input logic sign, input word_t wdata);
        int waited;
        if (timeouts > 0)
            return;                                  // DUT is stuck already
        @(negedge clock);
        address = addr;
        data_size = size;
        load_sign = sign;
        data_input = wdata;
        if (is_store) begin
            for (int i = 0; i < size_bytes(size); i++)
                shadow[int'(addr % MEM_BYTES) + i] = wdata[8*i +: 8];
            load_active = 1'b0;
        end else begin
            expected_data = expected_load(shadow_word(addr), int'(addr[2:0]), size, sign);
            load_active = 1'b1;
        end
        read_enable = !is_store;
        write_enable = is_store;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!send_enable && waited < TIMEOUT_CYCLES);
        if (!send_enable) begin
            timeouts++;
            $display("timeout: no send_enable for the access at %h", addr);
        end
        read_enable = 1'b0;
        write_enable = 1'b0;
    endtask

    // Compare process, loads only
    always @(negedge clock) begin
        if (!reset && send_enable && load_active)
            check("data_out", data_out, expected_data);
    end

    // Handshakes as the DUT sees them at the rising edge
    always @(posedge clock) begin
        if (reset) begin
            w_beats <= 0;
            read_open <= 1'b0;
            resp_open <= 1'b0;
        end else begin
            if (m_axi_awvalid && m_axi_awready)
                w_beats <= 0;
            else if (m_axi_wvalid && m_axi_wready)
                w_beats <= w_beats + 1;
            if (m_axi_arvalid && m_axi_arready)
                read_open <= 1'b1;
            else if (m_axi_rvalid && m_axi_rready && m_axi_rlast)
                read_open <= 1'b0;
            if (m_axi_wvalid && m_axi_wready && w_beats == `DC_LINE_BEATS - 1)
                resp_open <= 1'b1;
            else if (m_axi_bvalid && m_axi_bready)
                resp_open <= 1'b0;
        end
    end

    // Burst shape and ready levels on the AXI side
    always @(negedge clock) begin
        if (!reset) begin
            if (m_axi_arvalid) begin
                check("m_axi_arlen", word_t'(m_axi_arlen), 64'd7);
                check("m_axi_arsize", word_t'(m_axi_arsize), 64'd3);
                check("m_axi_arburst", word_t'(m_axi_arburst), 64'd1);
            end
            if (m_axi_awvalid) begin
                check("m_axi_awlen", word_t'(m_axi_awlen), 64'd7);
                check("m_axi_awsize", word_t'(m_axi_awsize), 64'd3);
                check("m_axi_awburst", word_t'(m_axi_awburst), 64'd1);
            end
            if (m_axi_wvalid) begin
                check("m_axi_wstrb", word_t'(m_axi_wstrb), 64'hff);
                check("m_axi_wlast", word_t'(m_axi_wlast),
                      word_t'(w_beats == `DC_LINE_BEATS - 1));
            end
            check("m_axi_rready", word_t'(m_axi_rready), word_t'(read_open));
            check("m_axi_bready", word_t'(m_axi_bready), word_t'(resp_open));
        end
    end

    initial begin : stimulus
        int n;
        word_t w;
        addr_t a;
        logic op_store;
        logic op_sign;
        void'($urandom(SEED));
        reset = 1'b1;
        read_enable = 1'b0;
        write_enable = 1'b0;
        address = '0;
        data_size = SIZE_D;
        load_sign = 1'b0;
        data_input = '0;
        load_active = 1'b0;
        expected_data = '0;
        mismatches = 0;
        timeouts = 0;
        for (int i = 0; i < MEM_BYTES / 8; i++) begin
            w = memory_word(addr_t'(i) << 3);
            for (int j = 0; j < 8; j++)
                shadow[8*i + j] = w[8*j +: 8];
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;

        access(1'b0, 64'h0000, SIZE_D, 1'b0, '0);    // Cold miss on line 0

        for (int nb = 1; nb <= 8; nb = nb * 2) begin
            for (int off = 0; off < 8; off += nb) begin
                access(1'b0, 64'h0048 + off, size_code(nb), 1'b0, '0);
                access(1'b0, 64'h0048 + off, size_code(nb), 1'b1, '0);
            end
        end

        access(1'b1, 64'h004c, SIZE_W, 1'b0, 64'h8bad_f00d);   // Store hit
        access(1'b0, 64'h0048, SIZE_D, 1'b0, '0);
        access(1'b0, 64'h004c, SIZE_W, 1'b1, '0);

        access(1'b1, 64'h0086, SIZE_H, 1'b0, 64'hc0de);        // Store miss
        access(1'b0, 64'h0080, SIZE_D, 1'b0, '0);

        // Set 0 holds two dirty lines, a third line pushes one out
        access(1'b1, 64'h0010, SIZE_D, 1'b0, 64'h0123_4567_89ab_cdef);
        access(1'b0, 64'h0100, SIZE_D, 1'b0, '0);
        // Three fills so far leave the round-robin pointer on way 1, line 0x80
        check("line_80_written_back", word_t'(line_in_memory(64'h0080)), 64'd1);
        check("line_00_written_back", word_t'(line_in_memory(64'h0000)), 64'd0);
        access(1'b0, 64'h0010, SIZE_D, 1'b0, '0);
        access(1'b0, 64'h0086, SIZE_H, 1'b1, '0);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            n = 1 << $urandom_range(3);
            a = addr_t'($urandom_range(5) * 64 + $urandom_range(7) * 8);
            a = a + addr_t'(n * $urandom_range(8 / n - 1));
            op_store = $urandom_range(1) == 1;
            op_sign = $urandom_range(1) == 1;
            access(op_store, a, size_code(n), op_sign, {$urandom, $urandom});
        end

        if (mem_stalled) begin
            timeouts++;
            $display("memory model gave up waiting for a DUT handshake");
        end
        $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_lane_align.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache_axi_master.sv
hw/dcache_top.sv
dv/axi_mem_model.sv
dv/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - hw

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_lane_align.sv
      - hw/dcache_store.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_axi_master.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/dcache_tb.sv
